// ==== source/rf_config.svh ====
//------------------------------------------------------------
// Register-file subsystem configuration
// Array geometry, AXI4-Lite address map and power-gate timing
//------------------------------------------------------------

`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

// Array geometry
`define RF_DEPTH     64
`define RF_AW        6
`define RF_DW        27

// AXI4-Lite byte address width and register map
`define AXI_AW       12
`define CTRL_ADDR    12'h100
`define STAT_ADDR    12'h104

// Cycles for the power-enable chain to settle
`define RF_PG_DELAY  4

`endif

// ==== source/rf_pkg.sv ====
//------------------------------------------------------------
// Register-file subsystem package
// Entry address and payload types, AXI response codes and the
// power-gating state encoding
//------------------------------------------------------------

`include "rf_config.svh"

package rf_pkg;

    // Entry index and payload of the array
    typedef logic [`RF_AW-1:0] rf_addr_t;
    typedef logic [`RF_DW-1:0] rf_data_t;

    // AXI4-Lite response codes, only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // Power state of the array
    // GOING_OFF and WAKING are the settle windows of the enable chain
    typedef enum logic [1:0] {
        PG_ON        = 2'd0,
        PG_GOING_OFF = 2'd1,
        PG_OFF       = 2'd2,
        PG_WAKING    = 2'd3
    } pg_state_t;

endpackage

// ==== source/rf_port_if.sv ====
//------------------------------------------------------------
// Register-file port bundle
// One write port and one read port with a registered read
//------------------------------------------------------------

`timescale 1ns/1ps

interface rf_port_if;

    import rf_pkg::*;

    // Write port, the write takes effect at the clock edge
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;

    // Read port, rdata is valid one cycle after re
    logic     re;
    rf_addr_t raddr;
    rf_data_t rdata;

    // Side that issues accesses
    modport requester (
        output we, waddr, wdata, re, raddr,
        input  rdata
    );

    // Side that stores the entries and returns read data
    modport responder (
        input  we, waddr, wdata, re, raddr,
        output rdata
    );

endinterface

// ==== source/rf_reset_sync.sv ====
//------------------------------------------------------------
// Reset synchronizer with scan bypass
// Asserts asynchronously and releases on the second clk edge
//------------------------------------------------------------

`timescale 1ns/1ps

module rf_reset_sync (
     input  logic clk
    ,input  logic arst_n
    ,input  logic scan_rstbypen
    ,input  logic scan_byprst_b
    ,output logic rst_n_sync
);

    // Two-stage shift chain, a one enters after reset is released
    logic [1:0] sync_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan mode the tester drives the reset directly
    assign rst_n_sync = scan_rstbypen ? scan_byprst_b : sync_q[1];

endmodule

// ==== source/rf_array_2p.sv ====
//------------------------------------------------------------
// Behavioral two-port register array
// Per-entry valid bits model the loss of contents on power-off
//------------------------------------------------------------

`timescale 1ns/1ps

`include "rf_config.svh"

module rf_array_2p (
     input  logic clk
    ,input  logic rst_n
    ,input  logic pwr_off
    ,rf_port_if.responder port
);

    import rf_pkg::*;

    // Entry storage qualified by the valid bits
    rf_data_t mem [`RF_DEPTH];

    // One bit per entry, set by a write and lost with power
    logic [`RF_DEPTH-1:0] valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (pwr_off) begin
            // Every entry is gone while the array has no supply
            valid_q <= '0;
        end else if (port.we) begin
            valid_q[port.waddr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.waddr] <= port.wdata;
        end
    end

    // Registered read where an entry not written since power-up reads zero
    always_ff @(posedge clk) begin
        if (port.re) begin
            port.rdata <= valid_q[port.raddr] ? mem[port.raddr] : '0;
        end
    end

endmodule

// ==== source/rf_pwr_gate.sv ====
//------------------------------------------------------------
// Power-gate control for the register array
// Delays the enable chain and derives the isolation state
//------------------------------------------------------------

`timescale 1ns/1ps

`include "rf_config.svh"

module rf_pwr_gate (
     input  logic clk
    ,input  logic rst_n
    ,input  logic pwr_enable_b_in
    ,input  logic isol_en
    ,output logic pwr_enable_b_out
    ,output logic pwr_off
    ,output logic isolate
);

    import rf_pkg::*;

    localparam int CNT_W = $clog2(`RF_PG_DELAY);

    // Loaded on the edge that sees the request, so the chain output
    // moves RF_PG_DELAY edges after the input changed
    localparam logic [CNT_W-1:0] SETTLE = CNT_W'(`RF_PG_DELAY - 2);

    pg_state_t        state_q;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PG_ON;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                PG_ON: begin
                    if (pwr_enable_b_in) begin
                        state_q <= PG_GOING_OFF;
                        cnt_q   <= SETTLE;
                    end
                end
                PG_GOING_OFF: begin
                    // A withdrawn request aborts before the chain moves
                    if (!pwr_enable_b_in) begin
                        state_q <= PG_ON;
                    end else if (cnt_q == '0) begin
                        state_q <= PG_OFF;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                PG_OFF: begin
                    if (!pwr_enable_b_in) begin
                        state_q <= PG_WAKING;
                        cnt_q   <= SETTLE;
                    end
                end
                default: begin
                    // PG_WAKING
                    if (pwr_enable_b_in) begin
                        state_q <= PG_OFF;
                    end else if (cnt_q == '0) begin
                        state_q <= PG_ON;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

    // The chain reports off from the end of the power-down settle
    // until the end of the wake-up settle
    assign pwr_enable_b_out = (state_q == PG_OFF) || (state_q == PG_WAKING);
    assign pwr_off          = (state_q == PG_OFF);

    // Outputs are clamped through any transition, not only when asked
    assign isolate = isol_en || (state_q != PG_ON);

endmodule

// ==== source/rf_pg_64x27.sv ====
//------------------------------------------------------------
// Power-gated 64x27 two-port register file
// Reset sync, power gate and array, with access blocking and
// read data clamping while isolated
//------------------------------------------------------------

`timescale 1ns/1ps

module rf_pg_64x27 (
     input  logic clk
    ,input  logic arst_n
    ,input  logic scan_rstbypen
    ,input  logic scan_byprst_b

    // Power management
    ,input  logic pwr_enable_b_in
    ,input  logic isol_en
    ,output logic pwr_enable_b_out

    ,rf_port_if.responder port
);

    logic rst_n_sync;
    logic pwr_off;
    logic isolate;

    // Array side of the isolation boundary
    rf_port_if arr_if ();

    rf_reset_sync u_reset_sync (
         .clk           (clk)
        ,.arst_n        (arst_n)
        ,.scan_rstbypen (scan_rstbypen)
        ,.scan_byprst_b (scan_byprst_b)
        ,.rst_n_sync    (rst_n_sync)
    );

    rf_pwr_gate u_pwr_gate (
         .clk              (clk)
        ,.rst_n            (rst_n_sync)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_off          (pwr_off)
        ,.isolate          (isolate)
    );

    //------------------------------------------------------------
    // Isolation cells

    // Enables are blocked so a gated array sees no accesses
    assign arr_if.we    = port.we && !isolate;
    assign arr_if.waddr = port.waddr;
    assign arr_if.wdata = port.wdata;
    assign arr_if.re    = port.re && !isolate;
    assign arr_if.raddr = port.raddr;

    // Floating array outputs are clamped low
    assign port.rdata = isolate ? '0 : arr_if.rdata;

    rf_array_2p u_array (
         .clk     (clk)
        ,.rst_n   (rst_n_sync)
        ,.pwr_off (pwr_off)
        ,.port    (arr_if.responder)
    );

endmodule

// ==== source/rf_axil_bridge.sv ====
//------------------------------------------------------------
// AXI4-Lite slave for the register-file subsystem
// Maps the array entries and the power control and status
// registers, one transaction per channel in flight
//------------------------------------------------------------

`timescale 1ns/1ps

`include "rf_config.svh"

module rf_axil_bridge (
     input  logic                 clk
    ,input  logic                 arst_n

    // Write address and data
    ,input  logic                 awvalid
    ,output logic                 awready
    ,input  logic [`AXI_AW-1:0]   awaddr
    ,input  logic                 wvalid
    ,output logic                 wready
    ,input  logic [31:0]          wdata
    ,input  logic [3:0]           wstrb

    // Write response
    ,output logic                 bvalid
    ,input  logic                 bready
    ,output rf_pkg::axi_resp_t    bresp

    // Read address and data
    ,input  logic                 arvalid
    ,output logic                 arready
    ,input  logic [`AXI_AW-1:0]   araddr
    ,output logic                 rvalid
    ,input  logic                 rready
    ,output logic [31:0]          rdata
    ,output rf_pkg::axi_resp_t    rresp

    // Power management of the array
    ,output logic                 pwr_enable_b_in
    ,output logic                 isol_en
    ,input  logic                 pwr_enable_b_out

    ,rf_port_if.requester         rf
);

    import rf_pkg::*;

    // Readies stay low until the first edge after reset
    logic live_q;

    // Control register, bit0 requests power-off and bit1 isolates
    logic [1:0] ctrl_q;

    // Entry accesses are refused while the array is not fully usable
    // This includes the settle window after a power-off request
    logic pg_block;

    assign pwr_enable_b_in = ctrl_q[0];
    assign isol_en         = ctrl_q[1];
    assign pg_block        = ctrl_q[0] || ctrl_q[1] || pwr_enable_b_out;

    //------------------------------------------------------------
    // Write channel

    logic               aw_full;
    logic               w_full;
    logic [`AXI_AW-1:0] aw_addr_q;
    logic [31:0]        w_data_q;
    logic               wr_go;
    logic               wr_is_entry;
    logic               wr_is_ctrl;
    logic               wr_err;

    // AW and W are taken independently, wstrb is ignored since every
    // write is a full word
    assign awready = live_q && !aw_full && !bvalid;
    assign wready  = live_q && !w_full && !bvalid;

    // Both halves are held, the write retires on the next edge
    assign wr_go = aw_full && w_full;

    // Entries sit below 0x100, one word each
    assign wr_is_entry = (aw_addr_q[`AXI_AW-1:`RF_AW+2] == '0);
    assign wr_is_ctrl  = (aw_addr_q == `CTRL_ADDR);
    assign wr_err      = wr_is_entry ? pg_block : !wr_is_ctrl;

    assign rf.we    = wr_go && wr_is_entry && !pg_block;
    assign rf.waddr = aw_addr_q[`RF_AW+1:2];
    assign rf.wdata = w_data_q[`RF_DW-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live_q  <= 1'b0;
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
            ctrl_q  <= '0;
        end else begin
            live_q <= 1'b1;
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end
            if (wvalid && wready) begin
                w_full <= 1'b1;
            end
            if (wr_go) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                bvalid  <= 1'b1;
                if (wr_is_ctrl) begin
                    ctrl_q <= w_data_q[1:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
        end
        if (wr_go) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    //------------------------------------------------------------
    // Read channel

    // rd_s1 issues the array read, rd_s2 waits for registered data
    logic               rd_s1;
    logic               rd_s2;
    logic [`AXI_AW-1:0] ar_addr_q;
    logic               rd_blk_q;
    logic               rd_is_entry;
    logic [31:0]        rd_word;
    axi_resp_t          rd_resp;

    assign arready     = live_q && !(rd_s1 || rd_s2 || rvalid);
    assign rd_is_entry = (ar_addr_q[`AXI_AW-1:`RF_AW+2] == '0);

    assign rf.re    = rd_s1 && rd_is_entry && !pg_block;
    assign rf.raddr = ar_addr_q[`RF_AW+1:2];

    // Response word chosen when the array data arrives
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        if (rd_is_entry) begin
            if (rd_blk_q) begin
                rd_resp = RESP_SLVERR;
            end else begin
                rd_word = 32'(rf.rdata);
            end
        end else if (ar_addr_q == `CTRL_ADDR) begin
            rd_word = 32'(ctrl_q);
        end else if (ar_addr_q == `STAT_ADDR) begin
            rd_word = 32'(pwr_enable_b_out);
        end else begin
            rd_resp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_s1  <= 1'b0;
            rd_s2  <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            rd_s1 <= arvalid && arready;
            rd_s2 <= rd_s1;
            if (rd_s2) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_addr_q <= araddr;
        end
        // Blocking is judged when the read is issued to the array
        if (rd_s1) begin
            rd_blk_q <= pg_block;
        end
        if (rd_s2) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

// ==== source/rf_subsys_top.sv ====
//------------------------------------------------------------
// Register-file subsystem top level
// AXI4-Lite bridge in front of the power-gated register file
//------------------------------------------------------------

`timescale 1ns/1ps

`include "rf_config.svh"

module rf_subsys_top (
     input  logic                 clk
    ,input  logic                 arst_n
    ,input  logic                 scan_rstbypen
    ,input  logic                 scan_byprst_b

    ,input  logic                 awvalid
    ,output logic                 awready
    ,input  logic [`AXI_AW-1:0]   awaddr
    ,input  logic                 wvalid
    ,output logic                 wready
    ,input  logic [31:0]          wdata
    ,input  logic [3:0]           wstrb
    ,output logic                 bvalid
    ,input  logic                 bready
    ,output rf_pkg::axi_resp_t    bresp

    ,input  logic                 arvalid
    ,output logic                 arready
    ,input  logic [`AXI_AW-1:0]   araddr
    ,output logic                 rvalid
    ,input  logic                 rready
    ,output logic [31:0]          rdata
    ,output rf_pkg::axi_resp_t    rresp

    ,output logic                 pwr_enable_b_out
);

    // Power chain between the control register and the array
    logic pwr_enable_b_in;
    logic isol_en;

    rf_port_if rf_if ();

    rf_axil_bridge u_bridge (
         .clk              (clk)
        ,.arst_n           (arst_n)
        ,.awvalid          (awvalid)
        ,.awready          (awready)
        ,.awaddr           (awaddr)
        ,.wvalid           (wvalid)
        ,.wready           (wready)
        ,.wdata            (wdata)
        ,.wstrb            (wstrb)
        ,.bvalid           (bvalid)
        ,.bready           (bready)
        ,.bresp            (bresp)
        ,.arvalid          (arvalid)
        ,.arready          (arready)
        ,.araddr           (araddr)
        ,.rvalid           (rvalid)
        ,.rready           (rready)
        ,.rdata            (rdata)
        ,.rresp            (rresp)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.rf               (rf_if.requester)
    );

    rf_pg_64x27 u_rf (
         .clk              (clk)
        ,.arst_n           (arst_n)
        ,.scan_rstbypen    (scan_rstbypen)
        ,.scan_byprst_b    (scan_byprst_b)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.port             (rf_if.responder)
    );

endmodule

// ==== tests/rf_subsys_chk.sv ====
//------------------------------------------------------------
// Protocol and power checks for the register-file subsystem
// Bound to the top level, reports through assertion failures
//------------------------------------------------------------

`timescale 1ns/1ps

`include "rf_config.svh"

module rf_subsys_chk (
     input  logic              clk
    ,input  logic              arst_n
    ,input  logic              bvalid
    ,input  logic              bready
    ,input  rf_pkg::axi_resp_t bresp
    ,input  logic              rvalid
    ,input  logic              rready
    ,input  logic [31:0]       rdata
    ,input  rf_pkg::axi_resp_t rresp
    ,input  logic              pwr_enable_b_in
    ,input  logic              pwr_enable_b_out
);

    // Number of failed assertions, read by the testbench at the end
    int err_count = 0;

    // A write response and its code hold until the master takes it
    b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("Write response dropped or changed before bready");
            err_count++;
        end

    // Same rule for the read response and its data
    r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("Read response dropped or changed before rready");
            err_count++;
        end

    // No response may be offered while reset is applied
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !bvalid && !rvalid)
        else begin
            $error("Response valid high during reset");
            err_count++;
        end

    // The enable chain only moves to a value seen at its input RF_PG_DELAY cycles back
    pwr_follow: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(pwr_enable_b_out) |-> $past(pwr_enable_b_in, `RF_PG_DELAY) == pwr_enable_b_out)
        else begin
            $error("pwr_enable_b_out changed without a delayed request");
            err_count++;
        end

endmodule

bind rf_subsys_top rf_subsys_chk u_chk (
     .clk              (clk)
    ,.arst_n           (arst_n)
    ,.bvalid           (bvalid)
    ,.bready           (bready)
    ,.bresp            (bresp)
    ,.rvalid           (rvalid)
    ,.rready           (rready)
    ,.rdata            (rdata)
    ,.rresp            (rresp)
    ,.pwr_enable_b_in  (pwr_enable_b_in)
    ,.pwr_enable_b_out (pwr_enable_b_out)
);

// ==== tests/rf_subsys_tb.sv ====
//------------------------------------------------------------
// Directed testbench for the register-file subsystem
// AXI4-Lite master tasks, an entry model and power sequences
//------------------------------------------------------------

`timescale 1ns/1ps

`include "rf_config.svh"

module rf_subsys_tb;

    import rf_pkg::*;

    // Cycles any single wait may take before the run is abandoned
    localparam int TIMEOUT = 100;

    logic               clk;
    logic               arst_n;
    logic               scan_rstbypen;
    logic               scan_byprst_b;
    logic               awvalid;
    logic               awready;
    logic [`AXI_AW-1:0] awaddr;
    logic               wvalid;
    logic               wready;
    logic [31:0]        wdata;
    logic [3:0]         wstrb;
    logic               bvalid;
    logic               bready;
    axi_resp_t          bresp;
    logic               arvalid;
    logic               arready;
    logic [`AXI_AW-1:0] araddr;
    logic               rvalid;
    logic               rready;
    logic [31:0]        rdata;
    axi_resp_t          rresp;
    logic               pwr_enable_b_out;

    // Expected entry contents where an invalid entry reads as zero
    logic [`RF_DW-1:0]  model_data [`RF_DEPTH];
    logic               model_valid [`RF_DEPTH];
    logic [31:0]        rng_state;

    rf_subsys_top UUT (.*);

    always #20 clk = ~clk;

    //------------------------------------------------------------
    // Helpers

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [`AXI_AW-1:0] entry_addr(input int idx);
        return `AXI_AW'(idx * 4);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    //------------------------------------------------------------
    // AXI4-Lite master tasks that start and return on a falling edge

    task automatic axi_write(input logic [`AXI_AW-1:0] addr, input logic [31:0] data,
                             input axi_resp_t exp_resp, input int hold);
        int        cnt;
        logic      aw_hit;
        logic      w_hit;
        axi_resp_t resp;
        aw_hit  = 1'b0;
        w_hit   = 1'b0;
        cnt     = 0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Readies come from registered state so they are settled here
        while (awvalid || wvalid) begin
            if (awvalid && awready) begin
                aw_hit = 1'b1;
            end
            if (wvalid && wready) begin
                w_hit = 1'b1;
            end
            @(negedge clk);
            if (aw_hit) begin
                awvalid = 1'b0;
            end
            if (w_hit) begin
                wvalid = 1'b0;
            end
            cnt++;
            if (cnt > TIMEOUT) begin
                stop_run("Timeout waiting for awready and wready");
            end
        end
        cnt = 0;
        while (!bvalid) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                stop_run("Timeout waiting for bvalid");
            end
        end
        // bvalid rises one cycle after the last handshake
        check_value("write response latency", cnt, 1);
        resp = bresp;
        repeat (hold) begin
            @(negedge clk);
            check_value("bvalid", bvalid, 1);
            check_value("bresp", bresp, resp);
            check_value("awready", awready, 0);
            check_value("wready", wready, 0);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_value("bvalid", bvalid, 0);
        check_value("bresp", resp, exp_resp);
    endtask

    task automatic read_bus(input logic [`AXI_AW-1:0] addr, input int hold,
                            output logic [31:0] data, output axi_resp_t resp);
        int   cnt;
        logic hit;
        cnt     = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (arvalid) begin
            hit = arready;
            @(negedge clk);
            if (hit) begin
                arvalid = 1'b0;
            end
            cnt++;
            if (cnt > TIMEOUT) begin
                stop_run("Timeout waiting for arready");
            end
        end
        cnt = 0;
        while (!rvalid) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                stop_run("Timeout waiting for rvalid");
            end
        end
        // The array read is issued in the next cycle and its data registered one cycle later
        check_value("read response latency", cnt, 2);
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            check_value("rvalid", rvalid, 1);
            check_value("rdata", rdata, data);
            check_value("rresp", rresp, resp);
            check_value("arready", arready, 0);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_value("rvalid", rvalid, 0);
    endtask

    task automatic axi_read(input logic [`AXI_AW-1:0] addr, input logic [31:0] exp_data,
                            input axi_resp_t exp_resp, input int hold);
        logic [31:0] data;
        axi_resp_t   resp;
        read_bus(addr, hold, data, resp);
        check_value("rdata", data, exp_data);
        check_value("rresp", resp, exp_resp);
    endtask

    // Reads the status register until the chain output reaches exp_bit
    task automatic poll_status(input logic exp_bit);
        logic [31:0] data;
        axi_resp_t   resp;
        int          polls;
        polls = 0;
        do begin
            read_bus(`STAT_ADDR, 0, data, resp);
            check_value("rresp", resp, RESP_OKAY);
            polls++;
            if (polls > 20) begin
                stop_run("Timeout polling the status register");
            end
        end while (data[0] !== exp_bit);
        // The top-level chain output agrees with the status bit
        check_value("pwr_enable_b_out", pwr_enable_b_out, 32'(exp_bit));
    endtask

    task automatic read_all_entries();
        for (int i = 0; i < `RF_DEPTH; i++) begin
            axi_read(entry_addr(i), model_valid[i] ? 32'(model_data[i]) : 32'h0,
                     RESP_OKAY, 0);
        end
    endtask

    //------------------------------------------------------------
    // Directed tests

    task automatic random_fill_and_readback();
        int          idx;
        logic [31:0] data;
        repeat (32) begin
            idx  = int'(next_random() % `RF_DEPTH);
            data = next_random();
            axi_write(entry_addr(idx), data, RESP_OKAY, 0);
            model_data[idx]  = data[`RF_DW-1:0];
            model_valid[idx] = 1'b1;
        end
        read_all_entries();
    endtask

    task automatic check_address_map();
        axi_write(12'h200, next_random(), RESP_SLVERR, 0);
        axi_write(12'h108, next_random(), RESP_SLVERR, 0);
        // The status register is read only and must not move
        axi_write(`STAT_ADDR, 32'h1, RESP_SLVERR, 0);
        axi_read(`STAT_ADDR, 32'h0, RESP_OKAY, 0);
        axi_read(12'h200, 32'h0, RESP_SLVERR, 0);
        axi_read(12'hFFC, 32'h0, RESP_SLVERR, 0);
        // Isolation alone keeps the contents, so a nonzero value is safe here
        axi_write(`CTRL_ADDR, 32'h2, RESP_OKAY, 0);
        axi_read(`CTRL_ADDR, 32'h2, RESP_OKAY, 0);
        axi_write(`CTRL_ADDR, 32'h0, RESP_OKAY, 0);
        axi_read(`CTRL_ADDR, 32'h0, RESP_OKAY, 0);
    endtask

    task automatic power_down_blocks_access();
        axi_write(`CTRL_ADDR, 32'h1, RESP_OKAY, 0);
        poll_status(1'b1);
        // The array has lost its contents once the chain reports off
        for (int i = 0; i < `RF_DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
        axi_read(`CTRL_ADDR, 32'h1, RESP_OKAY, 0);
        axi_read(entry_addr(5), 32'h0, RESP_SLVERR, 0);
        axi_write(entry_addr(5), next_random(), RESP_SLVERR, 0);
        axi_read(entry_addr(63), 32'h0, RESP_SLVERR, 0);
    endtask

    task automatic wake_up_clears_entries();
        int          idx;
        logic [31:0] data;
        axi_write(`CTRL_ADDR, 32'h0, RESP_OKAY, 0);
        poll_status(1'b0);
        read_all_entries();
        repeat (8) begin
            idx  = int'(next_random() % `RF_DEPTH);
            data = next_random();
            axi_write(entry_addr(idx), data, RESP_OKAY, 0);
            model_data[idx]  = data[`RF_DW-1:0];
            model_valid[idx] = 1'b1;
            axi_read(entry_addr(idx), 32'(model_data[idx]), RESP_OKAY, 0);
        end
    endtask

    task automatic isolation_keeps_contents();
        axi_write(`CTRL_ADDR, 32'h2, RESP_OKAY, 0);
        axi_read(`CTRL_ADDR, 32'h2, RESP_OKAY, 0);
        // Isolation alone leaves the supply and the chain untouched
        axi_read(`STAT_ADDR, 32'h0, RESP_OKAY, 0);
        check_value("pwr_enable_b_out", pwr_enable_b_out, 0);
        for (int i = 0; i < 4; i++) begin
            axi_read(entry_addr(i * 16), 32'h0, RESP_SLVERR, 0);
            axi_write(entry_addr(i * 16), next_random(), RESP_SLVERR, 0);
        end
        axi_write(`CTRL_ADDR, 32'h0, RESP_OKAY, 0);
        read_all_entries();
    endtask

    task automatic back_pressure_holds_response();
        int          hold;
        int          idx;
        logic [31:0] data;
        repeat (4) begin
            hold = int'(next_random() % 8) + 1;
            idx  = int'(next_random() % `RF_DEPTH);
            data = next_random();
            axi_write(entry_addr(idx), data, RESP_OKAY, hold);
            model_data[idx]  = data[`RF_DW-1:0];
            model_valid[idx] = 1'b1;
            hold = int'(next_random() % 8) + 1;
            axi_read(entry_addr(idx), 32'(model_data[idx]), RESP_OKAY, hold);
        end
        hold = int'(next_random() % 8) + 1;
        axi_read(12'h300, 32'h0, RESP_SLVERR, hold);
    endtask

    //------------------------------------------------------------
    // Sequence

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        scan_rstbypen = 1'b0;
        scan_byprst_b = 1'b1;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        wstrb         = 4'hF;
        bready        = 1'b0;
        arvalid       = 1'b0;
        araddr        = '0;
        rready        = 1'b0;
        rng_state     = 32'd30765;
        for (int i = 0; i < `RF_DEPTH; i++) begin
            model_data[i]  = '0;
            model_valid[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        // Nothing is offered and the array is powered while in reset
        check_value("awready", awready, 0);
        check_value("wready", wready, 0);
        check_value("arready", arready, 0);
        check_value("bvalid", bvalid, 0);
        check_value("rvalid", rvalid, 0);
        check_value("pwr_enable_b_out", pwr_enable_b_out, 0);
        arst_n = 1'b1;
        // Lets the array reset synchronizer release
        repeat (4) @(negedge clk);
        random_fill_and_readback();
        check_address_map();
        power_down_blocks_access();
        wake_up_clears_entries();
        isolation_keeps_contents();
        back_pressure_holds_response();
        if (UUT.u_chk.err_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_run("A bound protocol assertion failed during the run");
        end
    end

endmodule

// ==== rf_subsys.f ====
+incdir+source
source/rf_pkg.sv
source/rf_port_if.sv
source/rf_reset_sync.sv
source/rf_array_2p.sv
source/rf_pwr_gate.sv
source/rf_pg_64x27.sv
source/rf_axil_bridge.sv
source/rf_subsys_top.sv
tests/rf_subsys_chk.sv
tests/rf_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the register-file subsystem testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rf_subsys_tb \
    -f rf_subsys.f -o rf_subsys_sim > build.log 2>&1 \
    && ./obj_dir/rf_subsys_sim | tee sim.log
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
